/* src/tagger_pkg.sv */
////////////////////////////////////////////////////////////
// Time tagger shared definitions
// Field widths, tag word types, register map and design ID
////////////////////////////////////////////////////////////
`default_nettype none

package tagger_pkg;

   // Raw tag word and its fields
   localparam int TAG_WORD_W = 32;
   localparam int OP_W       = 2;
   localparam int CHANNEL_W  = 6;
   localparam int SUBTIME_W  = 24;

   // Wrap count and full timestamp, time = wrap * 2^24 + subtime
   localparam int WRAP_W     = 40;
   localparam int TIME_W     = 64;
   localparam int COUNT_W    = 32;

   // Wishbone word address and data widths
   localparam int WB_ADR_W   = 8;
   localparam int WB_DAT_W   = 32;

   localparam logic [WB_DAT_W-1:0] DESIGN_ID = 32'd1;

   // Global registers live in block 0
   localparam logic [WB_ADR_W-1:0] REG_ID    = 8'h00;
   localparam logic [WB_ADR_W-1:0] REG_NCH   = 8'h01;
   localparam logic [WB_ADR_W-1:0] REG_CLEAR = 8'h02;

   // Channel n occupies words 16*n .. 16*n+15
   localparam int CH_OFS_W = 4;
   localparam logic [CH_OFS_W-1:0] CH_RISE    = 4'h0;
   localparam logic [CH_OFS_W-1:0] CH_FALL    = 4'h1;
   localparam logic [CH_OFS_W-1:0] CH_TIME_LO = 4'h2;
   localparam logic [CH_OFS_W-1:0] CH_TIME_HI = 4'h3;

   // Word type in the top two bits, 2'b11 is treated like idle
   typedef enum logic [OP_W-1:0] {
      TAG_IDLE  = 2'b00,
      TAG_EVENT = 2'b01,
      TAG_WRAP  = 2'b10
   } tag_op_e;

   typedef logic signed [CHANNEL_W-1:0] channel_t;
   typedef logic [TIME_W-1:0]           timestamp_t;
   typedef logic [COUNT_W-1:0]          count_t;

endpackage

`default_nettype wire

/* src/tag_bus_if.sv */
////////////////////////////////////////////////////////////
// Decoded tag broadcast
// One-cycle event strobe from the decoder to all counters
////////////////////////////////////////////////////////////
`default_nettype none

interface tag_bus_if
   import tagger_pkg::*;
();
   // Strobe, no back-pressure since every counter accepts
   logic                 tag_valid;
   // Channel magnitude, always positive
   logic [CHANNEL_W-1:0] tag_channel;
   // High for a rising edge, low for a falling edge
   logic                 tag_rising;
   // Full 64-bit event time
   timestamp_t           tag_time;

   modport source (output tag_valid, output tag_channel, output tag_rising, output tag_time);
   modport sink   (input tag_valid, input tag_channel, input tag_rising, input tag_time);

endinterface

`default_nettype wire

/* src/tag_decoder.sv */
////////////////////////////////////////////////////////////
// Tag stream decoder
// Tracks the wrap count and broadcasts events with full
// 64-bit timestamps, one cycle after the word is accepted
////////////////////////////////////////////////////////////
`default_nettype none

module tag_decoder
   import tagger_pkg::*;
(
   input  logic                  sys_clk,
   input  logic                  sys_clk_rst,
   input  logic                  tag_valid_i,
   input  logic [TAG_WORD_W-1:0] tag_data_i,
   output logic                  tag_ready_o,
   tag_bus_if.source             tag_o
);

   logic                 accept;
   tag_op_e              op;
   channel_t             channel;
   logic [CHANNEL_W-1:0] channel_mag;
   logic [SUBTIME_W-1:0] subtime;
   logic [WRAP_W-1:0]    wrap_count;
   logic                 event_hit;

   // Always ready outside reset
   assign tag_ready_o = ~sys_clk_rst;
   assign accept      = tag_valid_i & tag_ready_o;

   // Field split of the raw word
   assign op      = tag_op_e'(tag_data_i[TAG_WORD_W-1 -: OP_W]);
   assign channel = channel_t'(tag_data_i[SUBTIME_W +: CHANNEL_W]);
   assign subtime = tag_data_i[SUBTIME_W-1:0];

   // Negative channel means falling edge; -32 maps to 32 and hits no counter
   assign channel_mag = channel[CHANNEL_W-1] ? CHANNEL_W'(-channel) : CHANNEL_W'(channel);

   // Channel 0 events are dropped here
   assign event_hit = accept && (op == TAG_EVENT) && (channel != '0);

   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         wrap_count      <= '0;
         tag_o.tag_valid <= 1'b0;
      end else begin
         tag_o.tag_valid <= event_hit;
         // Wrap word moves time forward by 2^24
         if (accept && (op == TAG_WRAP)) begin
            wrap_count <= wrap_count + 1'b1;
         end
      end
   end

   // Broadcast payload, only meaningful while the strobe is high
   always_ff @(posedge sys_clk) begin
      if (event_hit) begin
         tag_o.tag_channel <= channel_mag;
         tag_o.tag_rising  <= ~channel[CHANNEL_W-1];
         // Current wrap count in the upper 40 bits
         tag_o.tag_time    <= {wrap_count, subtime};
      end
   end

endmodule

`default_nettype wire

/* src/channel_counter.sv */
////////////////////////////////////////////////////////////
// Per-channel event counter
// Rising and falling edge counts plus last event time
////////////////////////////////////////////////////////////
`default_nettype none

module channel_counter
   import tagger_pkg::*;
#(
   parameter int CHANNEL_ID = 1
) (
   input  logic       sys_clk,
   input  logic       sys_clk_rst,
   input  logic       clear_i,
   tag_bus_if.sink    tag_i,
   output count_t     rise_count_o,
   output count_t     fall_count_o,
   output timestamp_t last_time_o
);

   // Own channel number at the bus width
   localparam logic [CHANNEL_W-1:0] MY_CHANNEL = CHANNEL_W'(CHANNEL_ID);

   logic hit;

   // Strobe addressed to this channel
   assign hit = tag_i.tag_valid && (tag_i.tag_channel == MY_CHANNEL);

   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         rise_count_o <= '0;
         fall_count_o <= '0;
         last_time_o  <= '0;
      end else if (clear_i) begin
         // Clear wins over an event in the same cycle
         rise_count_o <= '0;
         fall_count_o <= '0;
         last_time_o  <= '0;
      end else if (hit) begin
         // Counts roll over at 2^32
         if (tag_i.tag_rising) begin
            rise_count_o <= rise_count_o + 1'b1;
         end else begin
            fall_count_o <= fall_count_o + 1'b1;
         end
         last_time_o <= tag_i.tag_time;
      end
   end

endmodule

`default_nettype wire

/* src/counter_regs.sv */
////////////////////////////////////////////////////////////
// Wishbone classic register slave
// ID and channel count, per-channel counter readout and the
// clear command
////////////////////////////////////////////////////////////
`default_nettype none

module counter_regs
   import tagger_pkg::*;
#(
   parameter int N_CHANNELS = 4
) (
   input  logic                               sys_clk,
   input  logic                               sys_clk_rst,
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   input  logic [WB_ADR_W-1:0]                wb_adr_i,
   input  logic [WB_DAT_W-1:0]                wb_dat_i,
   output logic [WB_DAT_W-1:0]                wb_dat_o,
   output logic                               wb_ack_o,
   output logic                               clear_o,
   input  count_t     [N_CHANNELS-1:0]        rise_counts_i,
   input  count_t     [N_CHANNELS-1:0]        fall_counts_i,
   input  timestamp_t [N_CHANNELS-1:0]        last_times_i
);

   localparam int BLK_W = WB_ADR_W - CH_OFS_W;

   logic                req;
   logic [BLK_W-1:0]    blk;
   logic [BLK_W-1:0]    ch_idx;
   logic [CH_OFS_W-1:0] ofs;
   logic [WB_DAT_W-1:0] rd_data;

   // New request, the cycle with ack high is skipped
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   // Block number selects the channel, block 1 is array entry 0
   assign blk    = wb_adr_i[WB_ADR_W-1:CH_OFS_W];
   assign ofs    = wb_adr_i[CH_OFS_W-1:0];
   assign ch_idx = blk - 1'b1;

   // Read mux, unmapped words read as zero
   always_comb begin
      rd_data = '0;
      if (blk == '0) begin
         case (wb_adr_i)
            REG_ID:  rd_data = DESIGN_ID;
            REG_NCH: rd_data = WB_DAT_W'(N_CHANNELS);
            default: rd_data = '0;
         endcase
      end else if (blk <= N_CHANNELS) begin
         case (ofs)
            CH_RISE:    rd_data = rise_counts_i[ch_idx];
            CH_FALL:    rd_data = fall_counts_i[ch_idx];
            CH_TIME_LO: rd_data = last_times_i[ch_idx][WB_DAT_W-1:0];
            CH_TIME_HI: rd_data = last_times_i[ch_idx][TIME_W-1:WB_DAT_W];
            default:    rd_data = '0;
         endcase
      end
   end

   // Ack one cycle after the request, clear pulses alongside it
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         wb_ack_o <= 1'b0;
         clear_o  <= 1'b0;
      end else begin
         wb_ack_o <= req;
         clear_o  <= req && wb_we_i && (wb_adr_i == REG_CLEAR);
      end
   end

   // Write cycles echo the written word
   always_ff @(posedge sys_clk) begin
      if (req) begin
         wb_dat_o <= wb_we_i ? wb_dat_i : rd_data;
      end
   end

endmodule

`default_nettype wire

/* src/time_tagger_top.sv */
////////////////////////////////////////////////////////////
// Time tagger top level
// Tag decoder, a row of channel counters and the Wishbone
// register slave
////////////////////////////////////////////////////////////
`default_nettype none

module time_tagger_top
   import tagger_pkg::*;
#(
   parameter int N_CHANNELS = 4
) (
   input  logic                  sys_clk,
   input  logic                  sys_clk_rst,
   // Tag stream
   input  logic                  tag_valid_i,
   input  logic [TAG_WORD_W-1:0] tag_data_i,
   output logic                  tag_ready_o,
   // Wishbone classic slave
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   input  logic [WB_ADR_W-1:0]   wb_adr_i,
   input  logic [WB_DAT_W-1:0]   wb_dat_i,
   output logic [WB_DAT_W-1:0]   wb_dat_o,
   output logic                  wb_ack_o
);

   count_t     [N_CHANNELS-1:0] rise_counts;
   count_t     [N_CHANNELS-1:0] fall_counts;
   timestamp_t [N_CHANNELS-1:0] last_times;
   logic                        clear;

   tag_bus_if tag_bus ();

   tag_decoder tag_decoder_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .tag_valid_i (tag_valid_i),
      .tag_data_i  (tag_data_i),
      .tag_ready_o (tag_ready_o),
      .tag_o       (tag_bus.source)
   );

   // Channel numbers start at 1
   for (genvar i = 0; i < N_CHANNELS; i++) begin : g_channel
      channel_counter #(
         .CHANNEL_ID (i + 1)
      ) channel_counter_inst (
         .sys_clk      (sys_clk),
         .sys_clk_rst  (sys_clk_rst),
         .clear_i      (clear),
         .tag_i        (tag_bus.sink),
         .rise_count_o (rise_counts[i]),
         .fall_count_o (fall_counts[i]),
         .last_time_o  (last_times[i])
      );
   end

   counter_regs #(
      .N_CHANNELS (N_CHANNELS)
   ) counter_regs_inst (
      .sys_clk       (sys_clk),
      .sys_clk_rst   (sys_clk_rst),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .clear_o       (clear),
      .rise_counts_i (rise_counts),
      .fall_counts_i (fall_counts),
      .last_times_i  (last_times)
   );

endmodule

`default_nettype wire

/* dv/time_tagger_asserts.sv */
////////////////////////////////////////////////////////////
// Time tagger handshake checks
// Wishbone ack timing and tag stream ready during reset
////////////////////////////////////////////////////////////
`default_nettype none

module time_tagger_asserts (
   input wire logic sys_clk,
   input wire logic sys_clk_rst,
   input wire logic wb_cyc_i,
   input wire logic wb_stb_i,
   input wire logic wb_ack_o,
   input wire logic tag_ready_o
);

   // Ack only follows a request one cycle earlier
   ack_after_request: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
      else $error("Wishbone ack without a request in the previous cycle");

   // Single-cycle ack
   ack_single_cycle: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
      wb_ack_o |=> !wb_ack_o)
      else $error("Wishbone ack held high for two cycles");

   // No tag accepted during reset
   ready_low_in_reset: assert property (@(posedge sys_clk)
      sys_clk_rst |-> !tag_ready_o)
      else $error("Tag stream ready while reset is high");

endmodule

bind time_tagger_top time_tagger_asserts time_tagger_asserts_inst (
   .sys_clk     (sys_clk),
   .sys_clk_rst (sys_clk_rst),
   .wb_cyc_i    (wb_cyc_i),
   .wb_stb_i    (wb_stb_i),
   .wb_ack_o    (wb_ack_o),
   .tag_ready_o (tag_ready_o)
);

`default_nettype wire

/* dv/tb_time_tagger.sv */
////////////////////////////////////////////////////////////
// Time tagger testbench
// Table of tag words and Wishbone accesses checked against
// a reference model of counts, timestamps and wrap count
////////////////////////////////////////////////////////////
`default_nettype none

module tb_time_tagger
   import tagger_pkg::*;
();
   localparam int N_CH = 4;
   localparam logic [TAG_WORD_W-1:0] WRAP_WORD = 32'h8000_0000;

   typedef enum logic [1:0] {STEP_TAG, STEP_WRITE, STEP_READ} step_kind_e;
   typedef struct packed {
      step_kind_e          kind;
      logic [WB_ADR_W-1:0] addr;
      logic [WB_DAT_W-1:0] data;
      logic [WB_DAT_W-1:0] expected;
   } step_t;

   logic sys_clk, sys_clk_rst, tag_valid_i, tag_ready_o;
   logic [TAG_WORD_W-1:0] tag_data_i;
   logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [WB_ADR_W-1:0] wb_adr_i;
   logic [WB_DAT_W-1:0] wb_dat_i, wb_dat_o;

   step_t steps[$];
   // Reference model
   logic [WRAP_W-1:0] model_wrap;
   count_t            model_rise [1:N_CH];
   count_t            model_fall [1:N_CH];
   timestamp_t        model_time [1:N_CH];
   int data_errors = 0;
   int handshake_errors = 0;
   int cycle_count = 0;
   int cycle_limit = 100000;

   time_tagger_top #(.N_CHANNELS (N_CH)) time_tagger_top_inst (.*);

   initial begin
      sys_clk = 1'b0;
      forever #50 sys_clk = ~sys_clk;
   end

   // Run limit from the table length
   always @(posedge sys_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout, run stopped after %0d cycles", cycle_count);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // Event word with type 01, signed channel and subtime
   function automatic logic [31:0] event_word(input int ch, input logic [23:0] sub);
      return {2'b01, 6'(ch), sub};
   endfunction

   function automatic logic [31:0] read_value_for(input logic [7:0] addr);
      int blk;
      int ofs;
      blk = int'(addr) / 16;
      ofs = int'(addr) % 16;
      if (addr == 8'h00) return 32'd1;
      if (addr == 8'h01) return 32'(N_CH);
      if (blk < 1 || blk > N_CH) return 32'd0;
      case (ofs)
         0: return model_rise[blk];
         1: return model_fall[blk];
         2: return model_time[blk][31:0];
         3: return model_time[blk][63:32];
         default: return 32'd0;
      endcase
   endfunction

   // Model update follows the word type in bits 31..30
   task automatic append_tag(input logic [31:0] word);
      logic signed [5:0] ch;
      int mag;
      ch = word[29:24];
      mag = (ch < 0) ? -int'(ch) : int'(ch);
      if (word[31:30] == 2'b10) begin
         model_wrap = model_wrap + 40'd1;
      end else if (word[31:30] == 2'b01 && mag >= 1 && mag <= N_CH) begin
         if (ch > 0) model_rise[mag]++;
         else model_fall[mag]++;
         // Wrap count times 2^24 plus subtime
         model_time[mag] = (64'(model_wrap) << 24) + 64'(word[23:0]);
      end
      steps.push_back({STEP_TAG, 8'h00, word, 32'h0});
   endtask

   task automatic enqueue_write(input logic [7:0] addr, input logic [31:0] data);
      // Clear zeroes counts and times but keeps the wrap count
      if (addr == 8'h02) begin
         foreach (model_rise[c]) begin
            model_rise[c] = '0;
            model_fall[c] = '0;
            model_time[c] = '0;
         end
      end
      steps.push_back({STEP_WRITE, addr, data, 32'h0});
   endtask

   task automatic expect_read(input logic [7:0] addr);
      steps.push_back({STEP_READ, addr, 32'h0, read_value_for(addr)});
   endtask

   // All four words of one channel block
   task automatic expect_channel(input int ch);
      for (int ofs = 0; ofs < 4; ofs++) expect_read(8'(16 * ch + ofs));
   endtask

   task automatic send_tag(input logic [31:0] word);
      @(posedge sys_clk);
      tag_valid_i <= 1'b1;
      tag_data_i  <= word;
      @(negedge sys_clk);
      while (!tag_ready_o) @(negedge sys_clk);
      // Transfer happens on this edge
      @(posedge sys_clk);
      tag_valid_i <= 1'b0;
   endtask

   task automatic wb_transfer(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic acked);
      int waits;
      acked = 1'b0;
      rdata = '0;
      waits = 0;
      @(posedge sys_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= addr;
      wb_dat_i <= wdata;
      // Ack and data sampled mid cycle
      while (!acked && waits < 4) begin
         @(negedge sys_clk);
         waits++;
         if (wb_ack_o) begin
            acked = 1'b1;
            rdata = wb_dat_o;
         end
      end
      @(posedge sys_clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic build_table();
      expect_read(8'h00);
      expect_read(8'h01);
      expect_channel(1);
      // Rise and fall counted apart
      for (int n = 0; n < 3; n++) append_tag(event_word(1, 24'($urandom)));
      for (int n = 0; n < 2; n++) append_tag(event_word(-1, 24'($urandom)));
      append_tag(event_word(2, 24'($urandom)));
      for (int n = 0; n < 2; n++) append_tag(event_word(-3, 24'($urandom)));
      for (int n = 0; n < 2; n++) append_tag(event_word(4, 24'($urandom)));
      append_tag(event_word(-4, 24'($urandom)));
      for (int c = 1; c <= N_CH; c++) expect_channel(c);
      // Enough wraps to carry the timestamp into its high word
      for (int n = 0; n < 300; n++) append_tag(WRAP_WORD);
      append_tag(event_word(2, 24'($urandom)));
      append_tag(event_word(-4, 24'($urandom)));
      expect_channel(2);
      expect_channel(4);
      // Dropped words and an ignored write
      append_tag(event_word(0, 24'($urandom)));
      append_tag(event_word(5, 24'($urandom)));
      append_tag(event_word(-7, 24'($urandom)));
      append_tag(event_word(-32, 24'($urandom)));
      append_tag({2'b00, 30'($urandom)});
      enqueue_write(8'h10, 32'hFFFF_FFFF);
      for (int c = 1; c <= N_CH; c++) expect_channel(c);
      expect_read(8'h03);
      expect_read(8'h0F);
      expect_read(8'h14);
      expect_read(8'h1F);
      expect_read(8'h50);
      expect_read(8'hF3);
      // Wrap count carries on after a clear
      enqueue_write(8'h02, 32'h1);
      for (int c = 1; c <= N_CH; c++) expect_channel(c);
      append_tag(WRAP_WORD);
      append_tag(event_word(3, 24'($urandom)));
      expect_channel(3);
   endtask

   initial begin
      logic [31:0] got;
      logic        acked;
      void'($urandom(30036));
      sys_clk_rst = 1'b1;
      tag_valid_i = 1'b0;
      tag_data_i  = '0;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      model_wrap  = '0;
      foreach (model_rise[c]) begin
         model_rise[c] = '0;
         model_fall[c] = '0;
         model_time[c] = '0;
      end
      build_table();
      cycle_limit = 20 * steps.size() + 100;
      repeat (3) @(posedge sys_clk);
      sys_clk_rst <= 1'b0;
      @(negedge sys_clk);
      assert (tag_ready_o) else begin
         $display("Tag stream not ready after reset release");
         handshake_errors++;
      end
      foreach (steps[i]) begin
         if (steps[i].kind == STEP_TAG) begin
            send_tag(steps[i].data);
         end else begin
            wb_transfer(steps[i].kind == STEP_WRITE, steps[i].addr, steps[i].data, got, acked);
            assert (acked) else begin
               $display("No Wishbone ack within 4 cycles at address %h", steps[i].addr);
               handshake_errors++;
            end
            if (acked && steps[i].kind == STEP_READ) begin
               assert (got == steps[i].expected) else begin
                  $display("FAIL wb_dat_o addr %h expected %h got %h",
                           steps[i].addr, steps[i].expected, got);
                  data_errors++;
               end
            end
         end
      end
      $display("Error counts: data %0d, handshake %0d", data_errors, handshake_errors);
      if (data_errors == 0 && handshake_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
src/tagger_pkg.sv
src/tag_bus_if.sv
src/tag_decoder.sv
src/channel_counter.sv
src/counter_regs.sv
src/time_tagger_top.sv
dv/time_tagger_asserts.sv
dv/tb_time_tagger.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the time tagger testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal \
   --top-module tb_time_tagger \
   --Mdir obj_dir -o Vtb_time_tagger \
   -f tb.f

./obj_dir/Vtb_time_tagger | tee "$LOG"

# Result comes from the log
if grep -q "^TESTS PASSED$" "$LOG"; then
   echo "Simulation result: pass"
else
   echo "Simulation result: fail"
   exit 1
fi
